// File: flist.f
+incdir+include
src/upscale_pkg.sv
src/pixel_line_buffer.sv
src/window_shifter.sv
src/phase_sequencer.sv
src/cubic_filter.sv
src/upscale_top.sv
sim/tb_upscale.sv

// File: include/tb_ref_model.svh
// reference model with image types, edge-replicated padding and the expected output pixel.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef upscale_pkg::pixel_u src_img_t [upscale_pkg::SRC_H][upscale_pkg::SRC_W];
typedef upscale_pkg::pixel_u pad_img_t [upscale_pkg::PAD_H][upscale_pkg::PAD_W];

function automatic int tap_weight(input bit half, input int idx);
    if (half) begin
        return upscale_pkg::HALF_TAPS[idx];
    end
    return (idx == 1) ? 16 : 0;
endfunction

// one column/row of replication before, two after.
function automatic pad_img_t pad_frame(input src_img_t src);
    pad_img_t pad;
    int       sy;
    int       sx;
    for (int y = 0; y < upscale_pkg::PAD_H; y++) begin
        for (int x = 0; x < upscale_pkg::PAD_W; x++) begin
            sy = (y < 1) ? 0 : ((y - 1 > upscale_pkg::SRC_H - 1) ? upscale_pkg::SRC_H - 1 : y - 1);
            sx = (x < 1) ? 0 : ((x - 1 > upscale_pkg::SRC_W - 1) ? upscale_pkg::SRC_W - 1 : x - 1);
            pad[y][x] = src[sy][sx];
        end
    end
    return pad;
endfunction

// output k in raster order with four phases per source pixel.
function automatic upscale_pkg::pixel_u expected_pixel(input pad_img_t pad, input int k);
    upscale_pkg::pixel_u res;
    logic [7:0]          px;
    int                  sy;
    int                  sx;
    bit                  dy;
    bit                  dx;
    int                  h;
    int                  v;
    sy = (k / 4) / upscale_pkg::SRC_W;
    sx = (k / 4) % upscale_pkg::SRC_W;
    dy = ((k % 4) / 2) != 0;
    dx = (k % 2) != 0;
    for (int ch = 0; ch < 3; ch++) begin
        v = 0;
        for (int r = 0; r < 4; r++) begin
            h = 0;
            for (int c = 0; c < 4; c++) begin
                px = pad[sy+r][sx+c].raw[8*(2-ch) +: 8];
                h += tap_weight(dx, c) * int'(px);
            end
            v += tap_weight(dy, r) * h;
        end
        v = (v + 128) >>> upscale_pkg::WEIGHT_SHIFT;
        v = (v < 0) ? 0 : ((v > 255) ? 255 : v);
        res.raw[8*(2-ch) +: 8] = 8'(v);
    end
    return res;
endfunction

`endif

// File: sim/tb_upscale.sv
// upscaler testbench with stimulus, ready throttling, assertion checks and watchdog.
module tb_upscale;

    `include "tb_ref_model.svh"

    localparam int CLK_PERIOD   = 8;
    localparam int FRAMES       = 3;
    localparam int SRC_PIX      = upscale_pkg::SRC_W * upscale_pkg::SRC_H;
    localparam int PAD_PIX      = upscale_pkg::PAD_W * upscale_pkg::PAD_H;
    localparam int FRAME_OUT    = SRC_PIX * 4;
    localparam int TOTAL_IN     = FRAMES * PAD_PIX;
    localparam int TOTAL_OUT    = FRAMES * FRAME_OUT;
    localparam int WATCHDOG_CYC = FRAMES * PAD_PIX * 8 + 200;
    localparam logic [23:0] CONST_RGB = 24'h3c8ad2;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  in_valid;
    upscale_pkg::pixel_u   in_pix;
    logic                  in_ready;
    logic                  out_valid;
    upscale_pkg::out_pix_t out_data;
    logic                  out_ready;

    int                    seed = 22;
    logic                  pre_input = 1'b1;
    logic                  stim_on = 1'b0;
    int                    in_idx = 0;
    int                    out_idx = 0;
    int                    zero_hits = 0;
    int                    full_hits = 0;
    upscale_pkg::pixel_u   in_stream [TOTAL_IN];
    upscale_pkg::pixel_u   exp_mem [TOTAL_OUT];
    upscale_pkg::pixel_u   ctr_mem [FRAMES * SRC_PIX];
    logic [23:0]           exp_cur;
    logic [23:0]           ctr_cur;
    logic                  exp_last;
    logic                  out_xfer;

    upscale_top upscale_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pix    (in_pix),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    // constant, random and checkerboard frames sent back to back.
    task automatic build_frames();
        src_img_t src;
        pad_img_t pad;
        int       n;
        n = 0;
        for (int f = 0; f < FRAMES; f++) begin
            for (int y = 0; y < upscale_pkg::SRC_H; y++) begin
                for (int x = 0; x < upscale_pkg::SRC_W; x++) begin
                    case (f)
                        0:       src[y][x].raw = CONST_RGB;
                        1:       src[y][x].raw = 24'($random(seed));
                        default: src[y][x].raw = ((x + y) % 2 != 0) ? 24'hffffff : 24'h000000;
                    endcase
                    ctr_mem[f * SRC_PIX + y * upscale_pkg::SRC_W + x] = src[y][x];
                end
            end
            pad = pad_frame(src);
            for (int y = 0; y < upscale_pkg::PAD_H; y++) begin
                for (int x = 0; x < upscale_pkg::PAD_W; x++) begin
                    in_stream[n] = pad[y][x];
                    n++;
                end
            end
            for (int k = 0; k < FRAME_OUT; k++) begin
                exp_mem[f * FRAME_OUT + k] = expected_pixel(pad, k);
            end
        end
    endtask

    // ##########################################################
    // expected values for the next output transfer
    // ##########################################################
    assign out_xfer = out_valid & out_ready;
    assign exp_cur  = (out_idx < TOTAL_OUT) ? exp_mem[out_idx].raw : 24'h0;
    assign ctr_cur  = (out_idx < TOTAL_OUT) ? ctr_mem[out_idx / 4].raw : 24'h0;
    assign exp_last = ((out_idx % FRAME_OUT) == FRAME_OUT - 1);

    always @(posedge clk) begin
        if (rst_n && in_valid && in_ready) begin
            in_idx <= in_idx + 1;
        end
        if (rst_n && out_xfer) begin
            out_idx <= out_idx + 1;
            if (out_idx >= 2 * FRAME_OUT && out_idx % 4 != 0) begin
                if (out_data.pix.raw == 24'h000000) begin
                    zero_hits <= zero_hits + 1;   // clamped low.
                end
                if (out_data.pix.raw == 24'hffffff) begin
                    full_hits <= full_hits + 1;   // clamped high.
                end
            end
        end
    end

    // ##########################################################
    // checks
    // ##########################################################
    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        pre_input |-> (!out_valid && in_ready))
        else fail_run($sformatf("ERROR at %0t: not idle after reset", $time));

    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        out_xfer |-> (out_idx < TOTAL_OUT))
        else fail_run($sformatf("ERROR at %0t: output beyond the last frame", $time));

    a_pix_match: assert property (@(posedge clk) disable iff (!rst_n)
        out_xfer |-> (out_data.pix.raw == exp_cur))
        else fail_run($sformatf("ERROR at %0t: output %0d is %06h, expected %06h", $time,
            $sampled(out_idx), $sampled(out_data.pix.raw), $sampled(exp_cur)));

    a_centre: assert property (@(posedge clk) disable iff (!rst_n)
        (out_xfer && out_idx % 4 == 0) |-> (out_data.pix.raw == ctr_cur))
        else fail_run($sformatf("ERROR at %0t: phase 00 output %0d is %06h, source %06h",
            $time, $sampled(out_idx), $sampled(out_data.pix.raw), $sampled(ctr_cur)));

    a_const: assert property (@(posedge clk) disable iff (!rst_n)
        (out_xfer && out_idx < FRAME_OUT) |-> (out_data.pix.raw == CONST_RGB))
        else fail_run($sformatf("ERROR at %0t: constant frame output %0d is %06h", $time,
            $sampled(out_idx), $sampled(out_data.pix.raw)));

    a_last: assert property (@(posedge clk) disable iff (!rst_n)
        out_xfer |-> (out_data.last == exp_last))
        else fail_run($sformatf("ERROR at %0t: last flag %0b on output %0d", $time,
            $sampled(out_data.last), $sampled(out_idx)));

    // held output under back-pressure.
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else fail_run($sformatf("ERROR at %0t: output changed while stalled", $time));

    // ##########################################################
    // stimulus on the falling edge
    // ##########################################################
    always @(negedge clk) begin
        if (stim_on) begin
            if (in_idx < TOTAL_IN) begin
                in_valid <= ($random(seed) & 3) != 0;   // random gaps.
                in_pix   <= in_stream[in_idx];
            end else begin
                in_valid <= 1'b0;
            end
            out_ready <= ($random(seed) & 3) != 0;
        end
    end

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_pix.raw = 24'h0;
        out_ready  = 1'b0;
        build_frames();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);
        pre_input = 1'b0;
        stim_on   = 1'b1;
        wait (out_idx == TOTAL_OUT);
        repeat (20) @(negedge clk);   // let any stray output show up.
        if (in_idx == TOTAL_IN && out_idx == TOTAL_OUT && zero_hits > 0 && full_hits > 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run($sformatf("run incomplete: %0d inputs, %0d outputs, clamp hits %0d/%0d",
                in_idx, out_idx, zero_hits, full_hits));
        end
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        fail_run($sformatf("timeout: only %0d of %0d outputs arrived", out_idx, TOTAL_OUT));
    end

endmodule

// File: src/upscale_top.sv
// 2x bicubic upscaler top level joining window shifter, phase sequencer and cubic filter.
module upscale_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  upscale_pkg::pixel_u   in_pix,
    output logic                  in_ready,
    output logic                  out_valid,
    output upscale_pkg::out_pix_t out_data,
    input  logic                  out_ready
);

    upscale_pkg::window_t   win;
    logic                   win_valid;
    logic                   win_last;
    logic                   idle;
    logic                   shift_en;
    upscale_pkg::filt_req_t req;
    logic                   req_valid;
    logic                   req_ready;

    assign shift_en = in_valid & idle;   // input handshake.
    assign in_ready = idle;

    window_shifter window_shifter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift_en  (shift_en),
        .pix       (in_pix),
        .win       (win),
        .win_valid (win_valid),
        .win_last  (win_last)
    );

    phase_sequencer phase_sequencer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .win       (win),
        .win_valid (win_valid),
        .win_last  (win_last),
        .idle      (idle),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready)
    );

    cubic_filter cubic_filter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// File: src/cubic_filter.sv
// two-stage separable cubic filter with rounding, clamping and back-pressure.
module cubic_filter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  upscale_pkg::filt_req_t req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output upscale_pkg::out_pix_t  out_data,
    output logic                   out_valid,
    input  logic                   out_ready
);

    logic                s1_valid;
    logic                s1_dy;
    logic                s1_last;
    logic signed [13:0]  s1_h [4][3];
    logic signed [13:0]  h_next [4][3];
    logic [7:0]          v_next [3];
    upscale_pkg::pixel_u v_pix;
    logic                s2_adv;

    // phase 0 passes the centre tap at full scale.
    function automatic int tap(input logic half, input int idx);
        if (half) begin
            return upscale_pkg::HALF_TAPS[idx];
        end
        return (idx == 1) ? 16 : 0;
    endfunction

    function automatic int chan(input upscale_pkg::pixel_u p, input int c);
        case (c)
            0:       return int'(p.ch.r);
            1:       return int'(p.ch.g);
            default: return int'(p.ch.b);
        endcase
    endfunction

    assign s2_adv    = out_ready | ~out_valid;
    assign req_ready = ~s1_valid | s2_adv;

    // ##########################################################
    // stage 1 horizontal pass per row and channel
    // ##########################################################
    always_comb begin
        int acc;
        for (int r = 0; r < 4; r++) begin
            for (int ch = 0; ch < 3; ch++) begin
                acc = 0;
                for (int c = 0; c < 4; c++) begin
                    acc += tap(req.phase.dx, c) * chan(req.win[r][c], ch);
                end
                h_next[r][ch] = 14'(acc);   // within -510..4590.
            end
        end
    end

    // ##########################################################
    // stage 2 vertical pass with round and clamp
    // ##########################################################
    always_comb begin
        int acc;
        for (int ch = 0; ch < 3; ch++) begin
            acc = 0;
            for (int r = 0; r < 4; r++) begin
                acc += tap(s1_dy, r) * int'(s1_h[r][ch]);
            end
            acc = (acc + (1 << (upscale_pkg::WEIGHT_SHIFT - 1))) >>> upscale_pkg::WEIGHT_SHIFT;
            if (acc < 0) begin
                v_next[ch] = 8'd0;
            end else if (acc > 255) begin
                v_next[ch] = 8'd255;
            end else begin
                v_next[ch] = 8'(acc);
            end
        end
        v_pix.ch.r = v_next[0];
        v_pix.ch.g = v_next[1];
        v_pix.ch.b = v_next[2];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (req_ready) begin
                s1_valid <= req_valid;
            end
            if (s2_adv) begin
                out_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            s1_h    <= h_next;
            s1_dy   <= req.phase.dy;
            s1_last <= req.last;
        end
        if (s1_valid && s2_adv) begin
            out_data.pix  <= v_pix;
            out_data.last <= s1_last;
        end
    end

endmodule

// File: src/phase_sequencer.sv
// window holding register and four-phase request issue to the cubic filter.
module phase_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  upscale_pkg::window_t   win,
    input  logic                   win_valid,
    input  logic                   win_last,
    output logic                   idle,
    output upscale_pkg::filt_req_t req,
    output logic                   req_valid,
    input  logic                   req_ready
);

    upscale_pkg::window_t hold_win;
    logic                 hold_last;
    logic                 busy;
    logic [1:0]           phase_cnt;
    logic                 final_phase;

    assign final_phase = (phase_cnt == 2'd3);

    // a shift now would raise win_valid while busy.
    assign idle = ~busy & ~win_valid;

    assign req_valid    = busy;
    assign req.win      = hold_win;
    assign req.phase.dy = phase_cnt[1];
    assign req.phase.dx = phase_cnt[0];
    assign req.last     = hold_last & final_phase;

    always_ff @(posedge clk) begin
        if (win_valid) begin
            hold_win  <= win;
            hold_last <= win_last;
        end
    end

    // ##########################################################
    // phase order 00, 01, 10, 11
    // ##########################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            phase_cnt <= 2'd0;
        end else if (win_valid) begin
            busy      <= 1'b1;
            phase_cnt <= 2'd0;
        end else if (busy && req_ready) begin
            phase_cnt <= phase_cnt + 2'd1;
            if (final_phase) begin
                busy <= 1'b0;   // window done.
            end
        end
    end

endmodule

// File: src/window_shifter.sv
// 4x4 window registers, three row line buffers and padded position counters.
module window_shifter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 shift_en,
    input  upscale_pkg::pixel_u  pix,
    output upscale_pkg::window_t win,
    output logic                 win_valid,
    output logic                 win_last
);

    upscale_pkg::pixel_u           lb_out [3];
    logic [upscale_pkg::COL_W-1:0] col_cnt;
    logic [upscale_pkg::ROW_W-1:0] row_cnt;
    logic                          col_end;
    logic                          row_end;
    logic                          in_window;

    // ##########################################################
    // row delay lines each fed by the oldest pixel of the row below
    // ##########################################################
    pixel_line_buffer line_buf0_inst (
        .clk      (clk),
        .shift_en (shift_en),
        .din      (win[1][0]),
        .dout     (lb_out[0])
    );

    pixel_line_buffer line_buf1_inst (
        .clk      (clk),
        .shift_en (shift_en),
        .din      (win[2][0]),
        .dout     (lb_out[1])
    );

    pixel_line_buffer line_buf2_inst (
        .clk      (clk),
        .shift_en (shift_en),
        .din      (win[3][0]),
        .dout     (lb_out[2])
    );

    // ##########################################################
    // window registers
    // ##########################################################
    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 3; c++) begin
                    win[r][c] <= win[r][c+1];
                end
            end
            for (int r = 0; r < 3; r++) begin
                win[r][3] <= lb_out[r];
            end
            win[3][3] <= pix;   // newest row takes the stream.
        end
    end

    // ##########################################################
    // position of the incoming pixel in the padded frame
    // ##########################################################
    assign col_end   = (int'(col_cnt) == upscale_pkg::PAD_W - 1);
    assign row_end   = (int'(row_cnt) == upscale_pkg::PAD_H - 1);

    // full 4x4 neighbourhood once three rows and columns are behind us.
    assign in_window = (int'(col_cnt) >= 3) && (int'(row_cnt) >= 3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end else begin
            win_valid <= shift_en & in_window;
            win_last  <= shift_en & col_end & row_end;
            if (shift_en) begin
                if (col_end) begin
                    col_cnt <= '0;
                    if (row_end) begin
                        row_cnt <= '0;   // frame wraps.
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: src/pixel_line_buffer.sv
// shift-enabled pixel delay line covering one padded row outside the window.
module pixel_line_buffer (
    input  logic                clk,
    input  logic                shift_en,
    input  upscale_pkg::pixel_u din,
    output upscale_pkg::pixel_u dout
);

    upscale_pkg::pixel_u mem [upscale_pkg::LINE_DEPTH];

    always_ff @(posedge clk) begin
        if (shift_en) begin
            mem[0] <= din;
            for (int i = 1; i < upscale_pkg::LINE_DEPTH; i++) begin
                mem[i] <= mem[i-1];
            end
        end
    end

    assign dout = mem[upscale_pkg::LINE_DEPTH-1];   // oldest entry.

endmodule

// File: src/upscale_pkg.sv
// image geometry, cubic filter weights and the pixel, window and request types.
package upscale_pkg;

    // ##########################################################
    // geometry of the padded source frame
    // ##########################################################
    localparam int SRC_W      = 8;
    localparam int SRC_H      = 6;
    localparam int PAD_W      = SRC_W + 3;         // one left, two right.
    localparam int PAD_H      = SRC_H + 3;         // one top, two bottom.
    localparam int LINE_DEPTH = PAD_W - 4;         // row minus window columns.
    localparam int COL_W      = $clog2(PAD_W);
    localparam int ROW_W      = $clog2(PAD_H);

    // ##########################################################
    // cubic weights
    // ##########################################################
    localparam int HALF_TAPS [4] = '{-1, 9, 9, -1};  // scale 16.
    localparam int WEIGHT_SHIFT  = 8;                // both passes.

    // ##########################################################
    // stream types
    // ##########################################################
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // raw on the stream, channels inside the filter.
    typedef union packed {
        logic [23:0] raw;
        rgb_t        ch;
    } pixel_u;

    // index 0 is the oldest row and column.
    typedef pixel_u [3:0][3:0] window_t;

    typedef struct packed {
        logic dy;   // half position vertically.
        logic dx;   // half position horizontally.
    } phase_t;

    typedef struct packed {
        window_t win;
        phase_t  phase;
        logic    last;
    } filt_req_t;

    typedef struct packed {
        pixel_u pix;
        logic   last;
    } out_pix_t;

endpackage
